//--- src/cl_pkg.sv
`default_nettype none
// shared bus types, response codes and register offsets
// id words and handshake state enums for the counter control port

package cl_pkg;

  // -------------------- bus types
  typedef logic [31:0] axil_addr_t;              // byte address on the control bus
  typedef logic [31:0] axil_data_t;              // register data word
  typedef logic [3:0]  axil_strb_t;              // write byte enables
  typedef logic [1:0]  axil_resp_t;              // axi response code

  // -------------------- responses
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;    // unmapped or read-only access

  // identification words with the same values as the pci ids of the design
  localparam axil_data_t CL_ID0 = 32'hF000_1D0F; // device id, vendor id
  localparam axil_data_t CL_ID1 = 32'h1D51_FEDD; // subsystem ids

  // -------------------- register map
  // only the low 8 address bits take part in the decode
  localparam logic [7:0] REG_ID0    = 8'h00;     // ro
  localparam logic [7:0] REG_ID1    = 8'h04;     // ro
  localparam logic [7:0] REG_CTRL   = 8'h08;     // enable, oneshot, clear, load
  localparam logic [7:0] REG_TICK   = 8'h0C;     // prescaler terminal value
  localparam logic [7:0] REG_LOAD   = 8'h10;     // value taken on load
  localparam logic [7:0] REG_WMARK  = 8'h14;     // watermark threshold
  localparam logic [7:0] REG_STATUS = 8'h18;     // ro, count and flag

  // -------------------- handshake states
  typedef enum logic {
    WR_IDLE,                                     // waiting for aw and w together
    WR_RESP                                      // bvalid up, waiting for bready
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,                                     // waiting for ar
    RD_DATA                                      // rvalid up, waiting for rready
  } rd_state_e;

endpackage

`default_nettype wire

//--- src/axil_slave.sv
`timescale 1ns/1ps
`default_nettype none
// AXI4-Lite slave for the counter control port
// one write and one read in flight, single-cycle register strobes out,
// registered responses back

module axil_slave
  import cl_pkg::*;
(
  input  wire logic       clk_main_a0,
  input  wire logic       rst_main_n,
  // write address / data / response
  input  wire logic       awvalid,
  output logic            awready,
  input  wire axil_addr_t awaddr,
  input  wire logic       wvalid,
  output logic            wready,
  input  wire axil_data_t wdata,
  input  wire axil_strb_t wstrb,
  output logic            bvalid,
  input  wire logic       bready,
  output axil_resp_t      bresp,
  // read address / data
  input  wire logic       arvalid,
  output logic            arready,
  input  wire axil_addr_t araddr,
  output logic            rvalid,
  input  wire logic       rready,
  output axil_data_t      rdata,
  output axil_resp_t      rresp,
  // register access side
  output logic            reg_wr_en,
  output axil_addr_t      reg_wr_addr,
  output axil_data_t      reg_wr_data,
  output axil_strb_t      reg_wr_strb,
  input  wire logic       reg_wr_err,
  output logic            reg_rd_en,
  output axil_addr_t      reg_rd_addr,
  input  wire axil_data_t reg_rd_data,
  input  wire logic       reg_rd_err
);

  wr_state_e wr_state;
  rd_state_e rd_state;
  logic      wr_hs;                                  // aw and w taken this cycle
  logic      rd_hs;                                  // ar taken this cycle

  // --------------------
  // write channel
  assign wr_hs       = awvalid && wvalid && (wr_state == WR_IDLE);
  assign awready     = wr_hs;                        // address and data move as a pair
  assign wready      = wr_hs;
  assign reg_wr_en   = wr_hs;                        // register updates at this edge
  assign reg_wr_addr = awaddr;
  assign reg_wr_data = wdata;
  assign reg_wr_strb = wstrb;
  assign bvalid      = (wr_state == WR_RESP);

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      wr_state <= WR_IDLE;
    else if (wr_hs)
      wr_state <= WR_RESP;                           // response the next cycle
    else if (bvalid && bready)
      wr_state <= WR_IDLE;                           // master took it
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (wr_hs)
      bresp <= reg_wr_err ? RESP_SLVERR : RESP_OKAY; // held while bvalid waits
  end

  // --------------------
  // read channel
  assign rd_hs       = arvalid && (rd_state == RD_IDLE);
  assign arready     = rd_hs;                        // no ready while rvalid is stuck
  assign reg_rd_en   = rd_hs;
  assign reg_rd_addr = araddr;
  assign rvalid      = (rd_state == RD_DATA);

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      rd_state <= RD_IDLE;
    else if (rd_hs)
      rd_state <= RD_DATA;
    else if (rvalid && rready)
      rd_state <= RD_IDLE;
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (rd_hs)
    begin
      rdata <= reg_rd_data;                          // zero from regs on a miss
      rresp <= reg_rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // --------------------
  // protocol checks
  bvalid_hold_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    bvalid && !bready |=> bvalid);                   // response stays until taken

  rvalid_hold_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    rvalid && !rready |=> rvalid);

  awvalid_hold_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    awvalid && !awready |=> awvalid);                // master keeps the address up until taken

endmodule

`default_nettype wire

//--- src/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none
// counter register file with offset decode, byte strobes, clear/load pulses
// and the read mux for ids, settings and status

module ctrl_regs
  import cl_pkg::*;
#(
  parameter int TICK_W = 8,
  parameter int CNT_W  = 16
) (
  input  wire logic              clk_main_a0,
  input  wire logic              rst_main_n,
  input  wire logic              reg_wr_en,
  input  wire axil_addr_t        reg_wr_addr,
  input  wire axil_data_t        reg_wr_data,
  input  wire axil_strb_t        reg_wr_strb,
  output logic                   reg_wr_err,
  input  wire logic              reg_rd_en,
  input  wire axil_addr_t        reg_rd_addr,
  output axil_data_t             reg_rd_data,
  output logic                   reg_rd_err,
  input  wire logic [CNT_W-1:0]  count,
  input  wire logic              ge_watermark,
  output logic                   cnt_enable,
  output logic                   cnt_oneshot,
  output logic                   cnt_clear,
  output logic                   cnt_load,
  output logic [TICK_W-1:0]      tick_value,
  output logic [CNT_W-1:0]       load_value,
  output logic [CNT_W-1:0]       watermark
);

  logic wr_ctrl;                                     // write hits per register
  logic wr_tick;
  logic wr_load;
  logic wr_wmark;
  logic ctrl_b0;                                     // ctrl write with byte 0 enabled

  // merge enabled bytes of the new word over the old one
  function automatic axil_data_t merge_strb(axil_data_t old_val, axil_data_t new_val,
                                            axil_strb_t strb);
    axil_data_t res;
    res = old_val;
    for (int i = 0; i < $bits(axil_strb_t); i++)
      if (strb[i])
        res[8*i +: 8] = new_val[8*i +: 8];
    return res;
  endfunction

  // --------------------
  // write decode
  always_comb
  begin
    wr_ctrl    = 1'b0;
    wr_tick    = 1'b0;
    wr_load    = 1'b0;
    wr_wmark   = 1'b0;
    reg_wr_err = 1'b0;
    case (reg_wr_addr[7:0])
      REG_CTRL:  wr_ctrl  = reg_wr_en;
      REG_TICK:  wr_tick  = reg_wr_en;
      REG_LOAD:  wr_load  = reg_wr_en;
      REG_WMARK: wr_wmark = reg_wr_en;
      default:   reg_wr_err = 1'b1;                  // ids, status and holes
    endcase
  end

  assign ctrl_b0 = wr_ctrl && reg_wr_strb[0];        // all ctrl bits live in byte 0

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      cnt_clear   <= 1'b0;
      cnt_load    <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end
    else
    begin
      if (ctrl_b0)
      begin
        cnt_enable  <= reg_wr_data[0];
        cnt_oneshot <= reg_wr_data[1];
      end
      cnt_clear <= ctrl_b0 && reg_wr_data[2];        // one cycle after the handshake
      cnt_load  <= ctrl_b0 && reg_wr_data[3];
      if (wr_tick)
        tick_value <= TICK_W'(merge_strb(axil_data_t'(tick_value), reg_wr_data, reg_wr_strb));
      if (wr_load)
        load_value <= CNT_W'(merge_strb(axil_data_t'(load_value), reg_wr_data, reg_wr_strb));
      if (wr_wmark)
        watermark  <= CNT_W'(merge_strb(axil_data_t'(watermark), reg_wr_data, reg_wr_strb));
    end
  end

  // --------------------
  // read mux that stays quiet when no read is in progress
  always_comb
  begin
    reg_rd_data = '0;
    reg_rd_err  = 1'b0;
    if (reg_rd_en)
    begin
      case (reg_rd_addr[7:0])
        REG_ID0:   reg_rd_data = CL_ID0;
        REG_ID1:   reg_rd_data = CL_ID1;
        REG_CTRL:  reg_rd_data[1:0] = {cnt_oneshot, cnt_enable}; // pulse bits read 0
        REG_TICK:  reg_rd_data[TICK_W-1:0] = tick_value;
        REG_LOAD:  reg_rd_data[CNT_W-1:0] = load_value;
        REG_WMARK: reg_rd_data[CNT_W-1:0] = watermark;
        REG_STATUS:
        begin
          reg_rd_data[CNT_W-1:0] = count;
          reg_rd_data[16]        = ge_watermark;     // flag sits above the count
        end
        default:   reg_rd_err = 1'b1;                // data stays 0
      endcase
    end
  end

  // the slave needs a response cycle between writes, so pulses never merge
  clear_pulse_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    cnt_clear |=> !cnt_clear);
  load_pulse_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    cnt_load |=> !cnt_load);

endmodule

`default_nettype wire

//--- src/tick_counter.sv
`timescale 1ns/1ps
`default_nettype none
// prescaled event counter with load, clear, one-shot saturation
// and a registered watermark flag

module tick_counter #(
  parameter int TICK_W = 8,
  parameter int CNT_W  = 16
) (
  input  wire logic              clk_main_a0,
  input  wire logic              rst_main_n,
  input  wire logic              cnt_enable,
  input  wire logic              cnt_oneshot,
  input  wire logic              cnt_clear,        // highest priority
  input  wire logic              cnt_load,
  input  wire logic [TICK_W-1:0] tick_value,       // count every tick_value+1 cycles
  input  wire logic [CNT_W-1:0]  load_value,
  input  wire logic [CNT_W-1:0]  watermark,
  output logic [CNT_W-1:0]       count,
  output logic                   ge_watermark
);

  logic [TICK_W-1:0] presc;                        // prescaler
  logic              tick;                         // prescaler restarts this cycle
  logic              at_max;                       // count is all ones

  // >= so a tick value lowered below presc still restarts at once
  assign tick   = cnt_enable && (presc >= tick_value);
  assign at_max = &count;

  // --------------------
  // prescaler
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      presc <= '0;
    else if (cnt_clear || tick)
      presc <= '0;
    else if (cnt_enable)
      presc <= presc + 1'b1;
  end

  // --------------------
  // event counter
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      count <= '0;
    else if (cnt_clear)
      count <= '0;
    else if (cnt_load)
      count <= load_value;
    else if (tick && !(cnt_oneshot && at_max))
      count <= count + 1'b1;                       // wraps to 0 unless one-shot
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      ge_watermark <= 1'b0;
    else
      ge_watermark <= (count >= watermark);        // lags count by one cycle
  end

  // one-shot holds at all ones; only clear or load may bring it back
  oneshot_hold_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    cnt_oneshot && at_max && !cnt_clear && !cnt_load |=> count != '0);

endmodule

`default_nettype wire

//--- src/cl_counter_top.sv
`timescale 1ns/1ps
`default_nettype none
// counter top level wiring the AXI4-Lite slave, register file and tick counter

module cl_counter_top
  import cl_pkg::*;
#(
  parameter int TICK_W = 8,                        // prescaler width
  parameter int CNT_W  = 16                        // counter width of at most 16
) (
  input  wire logic       clk_main_a0,
  input  wire logic       rst_main_n,
  input  wire logic       awvalid,
  output logic            awready,
  input  wire axil_addr_t awaddr,
  input  wire logic       wvalid,
  output logic            wready,
  input  wire axil_data_t wdata,
  input  wire axil_strb_t wstrb,
  output logic            bvalid,
  input  wire logic       bready,
  output axil_resp_t      bresp,
  input  wire logic       arvalid,
  output logic            arready,
  input  wire axil_addr_t araddr,
  output logic            rvalid,
  input  wire logic       rready,
  output axil_data_t      rdata,
  output axil_resp_t      rresp
);

  // -------------------- slave to register file
  logic        reg_wr_en;
  axil_addr_t  reg_wr_addr;
  axil_data_t  reg_wr_data;
  axil_strb_t  reg_wr_strb;
  logic        reg_wr_err;
  logic        reg_rd_en;
  axil_addr_t  reg_rd_addr;
  axil_data_t  reg_rd_data;
  logic        reg_rd_err;

  // -------------------- register file to counter
  logic              cnt_enable;
  logic              cnt_oneshot;
  logic              cnt_clear;                    // single-cycle pulse
  logic              cnt_load;                     // single-cycle pulse
  logic [TICK_W-1:0] tick_value;
  logic [CNT_W-1:0]  load_value;
  logic [CNT_W-1:0]  watermark;
  logic [CNT_W-1:0]  count;
  logic              ge_watermark;

  axil_slave u_axil_slave (.*);                    // port names match the wires above

  ctrl_regs #(
    .TICK_W (TICK_W),
    .CNT_W  (CNT_W)
  ) u_ctrl_regs (.*);

  tick_counter #(
    .TICK_W (TICK_W),
    .CNT_W  (CNT_W)
  ) u_tick_counter (.*);

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none
// testbench clock, 20 ns period, and active-low reset for 10 cycles

module tb_clk_gen (
  output logic clk_main_a0,
  output logic rst_main_n
);

  localparam int HALF_PERIOD = 10;                 // ns
  localparam int RST_CYCLES  = 10;

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #HALF_PERIOD clk_main_a0 = ~clk_main_a0;
  end

  initial
  begin
    rst_main_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_main_a0);
    @(negedge clk_main_a0) rst_main_n = 1'b1;      // release away from the sampling edge
  end

endmodule

`default_nettype wire

//--- tests/tb_cl_counter.sv
`timescale 1ns/1ps
`default_nettype none
// directed tests for the counter top over AXI4-Lite
// bus tasks, value checks, cycle watchdog and the closing summary

module tb_cl_counter
  import cl_pkg::*;
();

  localparam int TICK_W         = 8;
  localparam int CNT_W          = 16;
  localparam int SEED           = 11;
  localparam int EST_CYCLES     = 1500;                    // rough length of all tests
  localparam int TIMEOUT_CYCLES = 3 * EST_CYCLES + 500;

  logic       clk_main_a0;
  logic       rst_main_n;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       bvalid;
  logic       bready;
  axil_resp_t bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  axil_data_t rdata;
  axil_resp_t rresp;
  int         cycle_cnt;
  int         last_wr_cycle;                               // cycle of the latest aw/w handshake
  int         val_errs;
  int         other_errs;

  tb_clk_gen clk_gen0 (.clk_main_a0(clk_main_a0), .rst_main_n(rst_main_n));

  cl_counter_top #(.TICK_W(TICK_W), .CNT_W(CNT_W)) dut0 (.*);

  // --------------------
  // checks
  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      $display("failure at %0t ns: %s", $time, what);
      other_errs++;
    end
  endtask

  // --------------------
  // bus tasks that change inputs on the falling edge
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int bhold, output axil_resp_t resp);
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    #1;
    while (!awready)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    expect_true(wready, "wready not raised together with awready");
    @(negedge clk_main_a0);                                // handshake was on the posedge before
    last_wr_cycle = cycle_cnt;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (int i = 0; i < bhold; i++)
    begin
      expect_true(bvalid, "bvalid dropped while bready was held low");
      @(negedge clk_main_a0);
    end
    expect_true(bvalid, "bvalid not high one cycle after the write handshake");
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    #1;
    while (!arready)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    expect_true(rvalid, "rvalid not high one cycle after the read handshake");
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  // write with full strobes and no back-pressure, expecting OKAY
  task automatic write_reg(input logic [7:0] off, input axil_data_t data);
    axil_resp_t resp;
    axil_write(axil_addr_t'(off), data, 4'hF, 0, resp);
    expect_equal("bresp", RESP_OKAY, resp);
  endtask

  task automatic read_status(output logic [CNT_W-1:0] cnt, output logic flag);
    axil_data_t data;
    axil_resp_t resp;
    axil_read(axil_addr_t'(REG_STATUS), data, resp);
    expect_equal("rresp", RESP_OKAY, resp);
    cnt  = data[CNT_W-1:0];
    flag = data[16];
  endtask

  // --------------------
  // directed tests
  task automatic reset_and_identity();
    axil_data_t data;
    axil_resp_t resp;
    expect_equal("bvalid", 0, bvalid);
    expect_equal("rvalid", 0, rvalid);
    axil_read(axil_addr_t'(REG_ID0), data, resp);
    expect_equal("rdata id0", CL_ID0, data);
    expect_equal("rresp", RESP_OKAY, resp);
    axil_read(axil_addr_t'(REG_ID1), data, resp);
    expect_equal("rdata id1", CL_ID1, data);
    expect_equal("rresp", RESP_OKAY, resp);
  endtask

  task automatic register_access();
    axil_data_t a;
    axil_data_t b;
    axil_data_t data;
    axil_resp_t resp;
    a = $urandom;
    write_reg(REG_TICK, a);
    axil_read(axil_addr_t'(REG_TICK), data, resp);
    expect_equal("rdata tick", a & 32'h0000_00FF, data);   // TICK_W bits
    a = $urandom;
    write_reg(REG_WMARK, a);
    axil_read(axil_addr_t'(REG_WMARK), data, resp);
    expect_equal("rdata wmark", a & 32'h0000_FFFF, data);  // CNT_W bits
    a = $urandom;
    b = $urandom;
    write_reg(REG_LOAD, a);
    axil_read(axil_addr_t'(REG_LOAD), data, resp);
    expect_equal("rdata load", a & 32'h0000_FFFF, data);
    axil_write(axil_addr_t'(REG_LOAD), b, 4'b0010, 0, resp); // byte 1 only
    axil_read(axil_addr_t'(REG_LOAD), data, resp);
    expect_equal("rdata load strb", (b & 32'h0000_FF00) | (a & 32'h0000_00FF), data);
    axil_write(axil_addr_t'(REG_ID0), a, 4'hF, 0, resp);
    expect_equal("bresp id0 write", RESP_SLVERR, resp);
    axil_write(32'h0000_0040, a, 4'hF, 0, resp);
    expect_equal("bresp unmapped", RESP_SLVERR, resp);
    axil_read(32'h0000_0040, data, resp);
    expect_equal("rresp unmapped", RESP_SLVERR, resp);
    expect_equal("rdata unmapped", 0, data);
    axil_write(axil_addr_t'(REG_TICK), 32'h5A, 4'hF, 5, resp); // bready low 5 cycles
    expect_equal("bresp held", RESP_OKAY, resp);
    write_reg(REG_WMARK, b);
    axil_read(axil_addr_t'(REG_WMARK), data, resp);
    expect_equal("rdata wmark after stall", b & 32'h0000_FFFF, data);
  endtask

  task automatic load_and_clear();
    logic [CNT_W-1:0] v;
    logic [CNT_W-1:0] cnt;
    logic             flag;
    v = CNT_W'($urandom);
    write_reg(REG_LOAD, axil_data_t'(v));
    write_reg(REG_CTRL, 32'h8);                            // load with the counter off
    read_status(cnt, flag);
    expect_equal("status count after load", v, cnt);
    write_reg(REG_CTRL, 32'h4);                            // clear
    read_status(cnt, flag);
    expect_equal("status count after clear", 0, cnt);
  endtask

  task automatic counting_rate();
    int               t;
    int               e;
    int               first;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt2;
    logic             flag;
    t = 2 + ($urandom % 4);
    write_reg(REG_TICK, t);
    write_reg(REG_CTRL, 32'h4);                            // prescaler and count to 0
    write_reg(REG_CTRL, 32'h1);
    first = last_wr_cycle;
    repeat (60) @(negedge clk_main_a0);
    write_reg(REG_CTRL, 32'h0);
    e = last_wr_cycle - first;
    read_status(cnt, flag);
    expect_true(cnt >= (e - 2) / (t + 1) && cnt <= (e + 2) / (t + 1),
                $sformatf("count %0d out of range for %0d cycles at tick %0d", cnt, e, t));
    read_status(cnt2, flag);
    expect_equal("status count while stopped", cnt, cnt2);
    read_status(cnt2, flag);
    expect_equal("status count while stopped", cnt, cnt2);
  endtask

  task automatic oneshot_vs_wrap(input logic oneshot);
    logic [CNT_W-1:0] cnt;
    logic             flag;
    write_reg(REG_TICK, 0);
    write_reg(REG_LOAD, 32'hFFFD);                         // all ones minus 2
    write_reg(REG_CTRL, 32'h8);
    write_reg(REG_CTRL, {30'd0, oneshot, 1'b1});
    repeat (17) @(negedge clk_main_a0);                    // about 20 enabled cycles
    write_reg(REG_CTRL, 32'h0);
    read_status(cnt, flag);
    if (oneshot)
      expect_equal("status count one-shot", 32'hFFFF, cnt);
    else
      expect_true(cnt < 20, $sformatf("wrapped count %0d is not below 20", cnt));
  endtask

  task automatic watermark_flag();
    logic [CNT_W-1:0] w;
    logic [CNT_W-1:0] cnt;
    logic             flag;
    w = CNT_W'(2 + ($urandom % 16'hFFF0));
    write_reg(REG_WMARK, axil_data_t'(w));
    for (int d = -1; d <= 1; d++)
    begin
      write_reg(REG_LOAD, axil_data_t'(w + d));
      write_reg(REG_CTRL, 32'h8);
      read_status(cnt, flag);
      expect_equal("status count", w + d, cnt);
      expect_equal("status ge_watermark", d >= 0, flag);
    end
  endtask

  // --------------------
  // watchdog
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk_main_a0);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    val_errs      = 0;
    other_errs    = 0;
    last_wr_cycle = 0;
    void'($urandom(SEED));
    @(posedge rst_main_n);
    @(negedge clk_main_a0);
    reset_and_identity();
    register_access();
    load_and_clear();
    counting_rate();
    oneshot_vs_wrap(1'b1);
    oneshot_vs_wrap(1'b0);
    watermark_flag();
    $display("done: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs + other_errs == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/cl_pkg.sv
src/axil_slave.sv
src/ctrl_regs.sv
src/tick_counter.sv
src/cl_counter_top.sv
tests/tb_clk_gen.sv
tests/tb_cl_counter.sv

//--- Bender.yml
package:
  name: cl_counter

sources:
  - files:
      - src/cl_pkg.sv
      - src/axil_slave.sv
      - src/ctrl_regs.sv
      - src/tick_counter.sv
      - src/cl_counter_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_cl_counter.sv
